/* tb.f */
src/memWbPkg.sv
src/storeAlign.sv
src/dataRam.sv
src/loadExtract.sv
src/hiloUnit.sv
src/writebackSelect.sv
src/memWbTop.sv
tests/memWbTb.sv

/* Bender.yml */
package:
  name: memWb

sources:
  - src/memWbPkg.sv
  - src/storeAlign.sv
  - src/dataRam.sv
  - src/loadExtract.sv
  - src/hiloUnit.sv
  - src/writebackSelect.sv
  - src/memWbTop.sv
  - target: test
    files:
      - tests/memWbTb.sv

/* tests/memWbTb.sv */
`timescale 1ns/1ps

module memWbTb;

	localparam int ramAddrBits = 8;
	localparam int numOps = 2000;
	localparam int numWords = 16;
	localparam int clkPeriod = 10;
	// reset, all ops, pipeline flush, some margin
	localparam int watchdogTime = (numOps + 2 + 3) * clkPeriod + 200;

	logic clk;
	logic rst;
	logic valid;
	memWbPkg::memOp_t op;
	logic [31:0] aluOut;
	logic [31:0] writeData;
	logic [63:0] aluOut64;
	logic memWrite;
	logic [3:0] sigWrite;
	logic [31:0] memWriteData;
	logic [ramAddrBits-1:0] memAddr;
	logic [31:0] result;
	logic resultValid;

	// reference model state
	logic [7:0] modelMem [numWords*4];
	logic [31:0] modelHi;
	logic [31:0] modelLo;
	// expected {writes register file, value} pairs in issue order
	logic [32:0] resultQ [$];
	// store bus expected one cycle after issue
	logic expWrite;
	logic [3:0] expStrb;
	logic [ramAddrBits-1:0] expAddr;
	logic [31:0] expData;
	int errorCount;
	int checkCount;
	int unsigned seedVal;

	memWbTop #(.ramAddrBits(ramAddrBits)) UUT (
		.clk(clk), .rst(rst), .valid(valid), .op(op),
		.aluOut(aluOut), .writeData(writeData), .aluOut64(aluOut64),
		.memWrite(memWrite), .sigWrite(sigWrite), .memWriteData(memWriteData),
		.memAddr(memAddr), .result(result), .resultValid(resultValid)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	task automatic checkValue(
		input string name,
		input logic [31:0] got,
		input logic [31:0] exp
	);
		checkCount++;
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
			errorCount++;
		end
	endtask

	// two idle cycles and an mfhi from reset state come first, then all words get filled
	task automatic driveOp(input int i);
		int wordIdx;
		if (i >= 3 && i < 3 + numWords)
			wordIdx = i - 3;
		else
			wordIdx = $urandom % numWords;
		valid = ($urandom % 8) != 0;
		op = memWbPkg::memOp_t'($urandom % 15);
		writeData = $urandom;
		aluOut64 = {$urandom, $urandom};
		// random bits above the word index must be ignored
		aluOut = ($urandom << (ramAddrBits + 2)) | (wordIdx << 2) | ($urandom % 4);
		if (i < 2) begin
			valid = 1'b0;
		end else if (i == 2) begin
			valid = 1'b1;
			op = memWbPkg::opMfhi;
		end else if (i < 3 + numWords) begin
			valid = 1'b1;
			op = memWbPkg::opSw;
		end
	endtask

	// applies the op just driven, in program order
	task automatic modelStep();
		int base;
		logic [1:0] offs;
		logic [7:0] byteVal;
		logic [15:0] halfVal;
		logic [31:0] res;
		logic writes;
		base = ((aluOut >> 2) % numWords) * 4;
		offs = aluOut[1:0];
		byteVal = modelMem[base + offs];
		halfVal = {modelMem[base + 2 * offs[1] + 1], modelMem[base + 2 * offs[1]]};
		expWrite = 1'b0;
		expStrb = 4'b0000;
		expAddr = (aluOut >> 2) & ((1 << ramAddrBits) - 1);
		expData = 32'd0;
		writes = valid;
		res = 32'd0;
		if (valid) begin
			case (op)
				memWbPkg::opAlu: res = aluOut;
				memWbPkg::opLb: res = {{24{byteVal[7]}}, byteVal};
				memWbPkg::opLbu: res = {24'd0, byteVal};
				memWbPkg::opLh: res = {{16{halfVal[15]}}, halfVal};
				memWbPkg::opLhu: res = {16'd0, halfVal};
				memWbPkg::opLw: res = {modelMem[base + 3], modelMem[base + 2],
					modelMem[base + 1], modelMem[base]};
				memWbPkg::opMfhi: res = modelHi;
				memWbPkg::opMflo: res = modelLo;
				default: writes = 1'b0;
			endcase
			// one strobe bit per model byte that gets written
			case (op)
				memWbPkg::opSb: begin
					expStrb[offs] = 1'b1;
					expData = {4{writeData[7:0]}};
					modelMem[base + offs] = writeData[7:0];
				end
				memWbPkg::opSh: begin
					expStrb[2 * offs[1]] = 1'b1;
					expStrb[2 * offs[1] + 1] = 1'b1;
					expData = {2{writeData[15:0]}};
					modelMem[base + 2 * offs[1]] = writeData[7:0];
					modelMem[base + 2 * offs[1] + 1] = writeData[15:8];
				end
				memWbPkg::opSw: begin
					expStrb = 4'b1111;
					expData = writeData;
					for (int k = 0; k < 4; k++)
						modelMem[base + k] = writeData[k*8 +: 8];
				end
				memWbPkg::opMult: begin
					modelHi = aluOut64[63:32];
					modelLo = aluOut64[31:0];
				end
				memWbPkg::opMthi: modelHi = aluOut;
				memWbPkg::opMtlo: modelLo = aluOut;
				default: ;
			endcase
			expWrite = expStrb != 4'b0000;
		end
		resultQ.push_back({writes, res});
	endtask

	// M outputs belong to the previous op, W result to the one before it
	task automatic checkOutputs();
		logic [32:0] expRes;
		checkValue("memWrite", memWrite, expWrite);
		checkValue("sigWrite", sigWrite, expStrb);
		if (expWrite) begin
			checkValue("memAddr", memAddr, expAddr);
			checkValue("memWriteData", memWriteData, expData);
		end
		if (resultQ.size() == 2) begin
			expRes = resultQ.pop_front();
			checkValue("resultValid", resultValid, expRes[32]);
			if (expRes[32])
				checkValue("result", result, expRes[31:0]);
		end else begin
			checkValue("resultValid", resultValid, 1'b0);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		seedVal = $urandom(32'h2189);
		errorCount = 0;
		checkCount = 0;
		modelHi = 32'd0;
		modelLo = 32'd0;
		expWrite = 1'b0;
		expStrb = 4'b0000;
		rst = 1'b1;
		valid = 1'b0;
		op = memWbPkg::opNop;
		aluOut = 32'd0;
		writeData = 32'd0;
		aluOut64 = 64'd0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < numOps + 2; i++) begin
			@(posedge clk);
			#1;
			checkOutputs();
			if (i < numOps) begin
				driveOp(i);
			end else begin
				// drain the pipeline
				valid = 1'b0;
				op = memWbPkg::opNop;
			end
			modelStep();
		end
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// hang guard
	initial begin
		#(watchdogTime);
		$display("timeout: run did not finish within %0d ns", watchdogTime);
		$display("Test failed");
		$finish;
	end

endmodule

/* src/memWbTop.sv */
`timescale 1ns/1ps

module memWbTop #(
	parameter int ramAddrBits = 8
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                valid,
	input  memWbPkg::memOp_t                    op,
	input  logic [memWbPkg::WORD_BITS-1:0]      aluOut,
	input  logic [memWbPkg::WORD_BITS-1:0]      writeData,
	input  logic [memWbPkg::PROD_BITS-1:0]      aluOut64,
	output logic                                memWrite,
	output logic [memWbPkg::STRB_BITS-1:0]      sigWrite,
	output logic [memWbPkg::WORD_BITS-1:0]      memWriteData,
	output logic [ramAddrBits-1:0]              memAddr,
	output logic [memWbPkg::WORD_BITS-1:0]      result,
	output logic                                resultValid
);

	// M stage
	logic                           validM;
	memWbPkg::memOp_t               opM;
	logic [memWbPkg::WORD_BITS-1:0] aluOutM;
	logic [1:0]                     byteOffsetM;

	// W stage
	memWbPkg::memOp_t               opW;
	logic [1:0]                     byteOffsetW;
	logic [memWbPkg::WORD_BITS-1:0] readDataW;
	logic [memWbPkg::WORD_BITS-1:0] loadData;
	logic [memWbPkg::WORD_BITS-1:0] hiW;
	logic [memWbPkg::WORD_BITS-1:0] loW;

	//////////////////////////////////////////////////////////////////////
	// load/store path
	//////////////////////////////////////////////////////////////////////

	storeAlign #(.ramAddrBits(ramAddrBits)) storeAlign0 (
		.clk(clk), .rst(rst), .valid(valid), .op(op),
		.aluOut(aluOut), .writeData(writeData),
		.memWrite(memWrite), .sigWrite(sigWrite), .memWriteData(memWriteData),
		.aluOutM(aluOutM), .addrM(memAddr), .byteOffsetM(byteOffsetM),
		.opM(opM), .validM(validM)
	);

	// RAM sees the same bus that leaves the top
	dataRam #(.ramAddrBits(ramAddrBits)) dataRam0 (
		.clk(clk), .memWrite(memWrite), .sigWrite(sigWrite),
		.addrM(memAddr), .memWriteData(memWriteData), .readDataW(readDataW)
	);

	loadExtract loadExtract0 (
		.readDataW(readDataW), .opW(opW), .byteOffsetW(byteOffsetW),
		.loadData(loadData)
	);

	//////////////////////////////////////////////////////////////////////
	// hi/lo path
	//////////////////////////////////////////////////////////////////////

	hiloUnit hiloUnit0 (
		.clk(clk), .rst(rst), .valid(valid), .op(op),
		.aluOut(aluOut), .aluOut64(aluOut64),
		.hiW(hiW), .loW(loW)
	);

	// combiner
	writebackSelect writebackSelect0 (
		.clk(clk), .rst(rst), .validM(validM), .opM(opM),
		.aluOutM(aluOutM), .byteOffsetM(byteOffsetM),
		.loadData(loadData), .hiW(hiW), .loW(loW),
		.opW(opW), .byteOffsetW(byteOffsetW),
		.result(result), .resultValid(resultValid)
	);

endmodule

/* src/writebackSelect.sv */
`timescale 1ns/1ps

module writebackSelect (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                validM,
	input  memWbPkg::memOp_t                    opM,
	input  logic [memWbPkg::WORD_BITS-1:0]      aluOutM,
	input  logic [1:0]                          byteOffsetM,
	input  logic [memWbPkg::WORD_BITS-1:0]      loadData,
	input  logic [memWbPkg::WORD_BITS-1:0]      hiW,
	input  logic [memWbPkg::WORD_BITS-1:0]      loW,
	output memWbPkg::memOp_t                    opW,
	output logic [1:0]                          byteOffsetW,
	output logic [memWbPkg::WORD_BITS-1:0]      result,
	output logic                                resultValid
);

	logic                           validW;
	logic [memWbPkg::WORD_BITS-1:0] aluOutW;
	logic                           writesReg;

	//////////////////////////////////////////////////////////////////////
	// W-stage register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			validW <= 1'b0;
			opW    <= memWbPkg::opNop;
		end else begin
			validW <= validM;
			opW    <= opM;
		end
	end

	// address offset travels along for lane selection
	always_ff @(posedge clk) begin
		aluOutW     <= aluOutM;
		byteOffsetW <= byteOffsetM;
	end

	//////////////////////////////////////////////////////////////////////
	// result select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		writesReg = 1'b1;
		case (opW)
			memWbPkg::opAlu:  result = aluOutW;
			memWbPkg::opLb, memWbPkg::opLbu, memWbPkg::opLh,
			memWbPkg::opLhu, memWbPkg::opLw:
				result = loadData;
			memWbPkg::opMfhi: result = hiW;
			memWbPkg::opMflo: result = loW;
			// stores, hi/lo writes and nop leave the register file alone
			default: begin
				result    = aluOutW;
				writesReg = 1'b0;
			end
		endcase
	end

	assign resultValid = validW && writesReg;

endmodule

/* src/hiloUnit.sv */
`timescale 1ns/1ps

module hiloUnit (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                valid,
	input  memWbPkg::memOp_t                    op,
	input  logic [memWbPkg::WORD_BITS-1:0]      aluOut,
	input  logic [memWbPkg::PROD_BITS-1:0]      aluOut64,
	output logic [memWbPkg::WORD_BITS-1:0]      hiW,
	output logic [memWbPkg::WORD_BITS-1:0]      loW
);

	logic                           writeHiLoM;
	memWbPkg::memOp_t               hiloOpM;
	logic [memWbPkg::PROD_BITS-1:0] prodM;
	logic [memWbPkg::WORD_BITS-1:0] aluOutM;
	logic [memWbPkg::WORD_BITS-1:0] hi;
	logic [memWbPkg::WORD_BITS-1:0] lo;
	logic [memWbPkg::WORD_BITS-1:0] hiNext;
	logic [memWbPkg::WORD_BITS-1:0] loNext;

	// M stage, write enable
	always_ff @(posedge clk) begin
		if (rst) begin
			writeHiLoM <= 1'b0;
		end else begin
			writeHiLoM <= valid && (op == memWbPkg::opMult || op == memWbPkg::opMthi ||
				op == memWbPkg::opMtlo);
		end
	end

	// M stage, product and operands
	always_ff @(posedge clk) begin
		hiloOpM <= op;
		prodM   <= aluOut64;
		aluOutM <= aluOut;
	end

	// next hi/lo pair
	always_comb begin
		hiNext = hi;
		loNext = lo;
		if (writeHiLoM) begin
			case (hiloOpM)
				memWbPkg::opMult: begin
					hiNext = prodM[memWbPkg::PROD_BITS-1:memWbPkg::WORD_BITS];
					loNext = prodM[memWbPkg::WORD_BITS-1:0];
				end
				memWbPkg::opMthi: hiNext = aluOutM;
				memWbPkg::opMtlo: loNext = aluOutM;
				default: ;
			endcase
		end
	end

	// architectural registers
	always_ff @(posedge clk) begin
		if (rst) begin
			hi <= '0;
			lo <= '0;
		end else begin
			hi <= hiNext;
			lo <= loNext;
		end
	end

	// W copies take the updated pair, so a move-from right after a write sees it
	always_ff @(posedge clk) begin
		hiW <= hiNext;
		loW <= loNext;
	end

endmodule

/* src/loadExtract.sv */
`timescale 1ns/1ps

module loadExtract (
	input  logic [memWbPkg::WORD_BITS-1:0]      readDataW,
	input  memWbPkg::memOp_t                    opW,
	input  logic [1:0]                          byteOffsetW,
	output logic [memWbPkg::WORD_BITS-1:0]      loadData
);

	logic [7:0]  byteSel;
	logic [15:0] halfSel;

	//////////////////////////////////////////////////////////////////////
	// lane selection
	//////////////////////////////////////////////////////////////////////

	// byte at offset k sits in bits 8k+7:8k
	always_comb begin
		case (byteOffsetW)
			2'd0:    byteSel = readDataW[7:0];
			2'd1:    byteSel = readDataW[15:8];
			2'd2:    byteSel = readDataW[23:16];
			default: byteSel = readDataW[31:24];
		endcase
	end

	// bit 0 ignored for halfwords
	assign halfSel = byteOffsetW[1] ? readDataW[31:16] : readDataW[15:0];

	//////////////////////////////////////////////////////////////////////
	// extension
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (opW)
			memWbPkg::opLb:
				loadData = {{24{byteSel[7]}}, byteSel};
			memWbPkg::opLbu:
				loadData = {24'd0, byteSel};
			memWbPkg::opLh:
				loadData = {{16{halfSel[15]}}, halfSel};
			memWbPkg::opLhu:
				loadData = {16'd0, halfSel};
			// whole word, address bits 1:0 ignored
			default:
				loadData = readDataW;
		endcase
	end

endmodule

/* src/dataRam.sv */
`timescale 1ns/1ps

module dataRam #(
	parameter int ramAddrBits = 8
) (
	input  logic                                clk,
	input  logic                                memWrite,
	input  logic [memWbPkg::STRB_BITS-1:0]      sigWrite,
	input  logic [ramAddrBits-1:0]              addrM,
	input  logic [memWbPkg::WORD_BITS-1:0]      memWriteData,
	output logic [memWbPkg::WORD_BITS-1:0]      readDataW
);

	// word-organized storage
	logic [memWbPkg::WORD_BITS-1:0] mem [2**ramAddrBits];
	logic [memWbPkg::WORD_BITS-1:0] mergedWord;

	// write-first view of the addressed word
	always_comb begin
		mergedWord = mem[addrM];
		for (int i = 0; i < memWbPkg::STRB_BITS; i++) begin
			if (memWrite && sigWrite[i]) begin
				mergedWord[i*8 +: 8] = memWriteData[i*8 +: 8];
			end
		end
	end

	// byte lanes written only under their strobe
	always_ff @(posedge clk) begin
		for (int i = 0; i < memWbPkg::STRB_BITS; i++) begin
			if (memWrite && sigWrite[i]) begin
				mem[addrM][i*8 +: 8] <= memWriteData[i*8 +: 8];
			end
		end
	end

	// registered read, every cycle
	always_ff @(posedge clk) begin
		readDataW <= mergedWord;
	end

endmodule

/* src/storeAlign.sv */
`timescale 1ns/1ps

module storeAlign #(
	parameter int ramAddrBits = 8
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                valid,
	input  memWbPkg::memOp_t                    op,
	input  logic [memWbPkg::WORD_BITS-1:0]      aluOut,
	input  logic [memWbPkg::WORD_BITS-1:0]      writeData,
	output logic                                memWrite,
	output logic [memWbPkg::STRB_BITS-1:0]      sigWrite,
	output logic [memWbPkg::WORD_BITS-1:0]      memWriteData,
	output logic [memWbPkg::WORD_BITS-1:0]      aluOutM,
	output logic [ramAddrBits-1:0]              addrM,
	output logic [1:0]                          byteOffsetM,
	output memWbPkg::memOp_t                    opM,
	output logic                                validM
);

	logic [memWbPkg::STRB_BITS-1:0] strbNext;
	logic [memWbPkg::WORD_BITS-1:0] dataNext;
	logic [1:0]                     byteOffset;

	// low address bits pick the lane
	assign byteOffset = aluOut[1:0];

	// strobes and lane replication, little-endian lanes
	always_comb begin
		strbNext = '0;
		dataNext = writeData;
		case (op)
			memWbPkg::opSb: begin
				strbNext = 4'b0001 << byteOffset;
				dataNext = {4{writeData[7:0]}};
			end
			memWbPkg::opSh: begin
				// bit 1 picks upper or lower half
				strbNext = byteOffset[1] ? 4'b1100 : 4'b0011;
				dataNext = {2{writeData[15:0]}};
			end
			memWbPkg::opSw: begin
				strbNext = 4'b1111;
			end
			default: ;
		endcase
	end

	// control side of the M-stage register
	always_ff @(posedge clk) begin
		if (rst) begin
			validM   <= 1'b0;
			opM      <= memWbPkg::opNop;
			memWrite <= 1'b0;
			sigWrite <= '0;
		end else begin
			validM   <= valid;
			opM      <= op;
			memWrite <= valid && (strbNext != '0);
			sigWrite <= valid ? strbNext : '0;
		end
	end

	// payload, word index drops byte bits and high bits
	always_ff @(posedge clk) begin
		aluOutM      <= aluOut;
		addrM        <= aluOut[ramAddrBits+1:2];
		byteOffsetM  <= byteOffset;
		memWriteData <= dataNext;
	end

endmodule

/* src/memWbPkg.sv */
package memWbPkg;

	//////////////////////////////////////////////////////////////////////
	// widths shared by both paths
	//////////////////////////////////////////////////////////////////////

	// data word
	localparam int WORD_BITS = 32;
	// full multiply product, hi:lo
	localparam int PROD_BITS = 64;
	// one strobe per byte lane
	localparam int STRB_BITS = 4;

	//////////////////////////////////////////////////////////////////////
	// operations handed over by the execute stage
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		opNop,
		opAlu,
		// loads
		opLb, opLbu, opLh, opLhu, opLw,
		// stores
		opSb, opSh, opSw,
		// hi/lo writes
		opMult, opMthi, opMtlo,
		// hi/lo reads
		opMfhi, opMflo
	} memOp_t;

endpackage
